// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
TOP       ?= mem_subsystem_tb
FLIST     ?= flist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

// ==== arbiter/cache_arbiter.sv ====
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module cache_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_sys_pkg::cache_req_t icache_req,
    input  mem_sys_pkg::cache_req_t dcache_req,
    input  logic                   pf_hit,
    input  mem_sys_pkg::line_t     pf_data,
    input  mem_sys_pkg::word_t     pf_next_addr,
    input  mem_sys_pkg::bus_rsp_t  bus_rsp,
    output mem_sys_pkg::cache_rsp_t icache_rsp,
    output mem_sys_pkg::cache_rsp_t dcache_rsp,
    output mem_sys_pkg::pf_ctl_t   pf_ctl,
    output mem_sys_pkg::bus_req_t  bus_req
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ICACHE,
        ST_DCACHE,
        ST_PREFETCH
    } state_t;

    // Only one other client can be waiting while one is being served.
    typedef enum logic [1:0] {
        PEND_NONE,
        PEND_ICACHE,
        PEND_DCACHE
    } pend_t;

    state_t             state;
    state_t             state_next;
    pend_t              pending;
    logic               icache_wants;
    logic               dcache_wants;
    logic               have_iaddr;   // An instruction line has been handled since reset.
    mem_sys_pkg::word_t pf_addr_q;    // Line being prefetched.

    assign icache_wants = icache_req.read;
    assign dcache_wants = dcache_req.read | dcache_req.write;

    function automatic mem_sys_pkg::word_t line_base(input mem_sys_pkg::word_t addr);
        return {addr[`MEM_ADDR_BITS-1:`MEM_OFFSET_BITS], {`MEM_OFFSET_BITS{1'b0}}};
    endfunction

    always_comb begin
        case (state)
            ST_ICACHE:   pending = dcache_wants ? PEND_DCACHE : PEND_NONE;
            ST_DCACHE:   pending = icache_wants ? PEND_ICACHE : PEND_NONE;
            ST_PREFETCH: begin
                // The prefetch finishes first, then icache wins over dcache.
                if (icache_wants)
                    pending = PEND_ICACHE;
                else if (dcache_wants)
                    pending = PEND_DCACHE;
                else
                    pending = PEND_NONE;
            end
            default:     pending = PEND_NONE;
        endcase
    end

    always_comb begin
        icache_rsp         = '0;
        dcache_rsp         = '0;
        bus_req            = '0;
        pf_ctl             = '0;
        pf_ctl.lookup_addr = pf_next_addr;  // In idle the buffer is asked about the next line.
        case (state)
            ST_ICACHE: begin
                pf_ctl.lookup_addr = icache_req.addr;
                if (pf_hit) begin
                    icache_rsp.resp  = 1'b1;  // Served from the buffer in this cycle.
                    icache_rsp.rdata = pf_data;
                end else begin
                    bus_req.valid    = 1'b1;
                    bus_req.adr      = line_base(icache_req.addr);
                    icache_rsp.resp  = bus_rsp.done;
                    icache_rsp.rdata = bus_rsp.dat;
                end
            end
            ST_DCACHE: begin
                bus_req.valid    = 1'b1;
                bus_req.we       = dcache_req.write;
                bus_req.adr      = line_base(dcache_req.addr);
                bus_req.dat      = dcache_req.wdata;
                dcache_rsp.resp  = bus_rsp.done;
                dcache_rsp.rdata = bus_rsp.dat;
                // A finished write makes a buffered copy of the line stale.
                pf_ctl.inval      = dcache_req.write & bus_rsp.done;
                pf_ctl.inval_addr = dcache_req.addr;
            end
            ST_PREFETCH: begin
                bus_req.valid    = 1'b1;
                bus_req.adr      = pf_addr_q;
                pf_ctl.fill      = bus_rsp.done;
                pf_ctl.fill_addr = pf_addr_q;
                pf_ctl.fill_data = bus_rsp.dat;
            end
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (icache_wants)
                    state_next = ST_ICACHE;
                else if (dcache_wants)
                    state_next = ST_DCACHE;
                else if (have_iaddr && !pf_hit)
                    state_next = ST_PREFETCH;  // Bus is quiet and the next line is missing.
            end
            ST_ICACHE: begin
                if (pf_hit || bus_rsp.done)
                    state_next = (pending == PEND_DCACHE) ? ST_DCACHE : ST_IDLE;
            end
            ST_DCACHE: begin
                if (bus_rsp.done)
                    state_next = (pending == PEND_ICACHE) ? ST_ICACHE : ST_IDLE;
            end
            ST_PREFETCH: begin
                if (bus_rsp.done) begin
                    case (pending)
                        PEND_ICACHE: state_next = ST_ICACHE;
                        PEND_DCACHE: state_next = ST_DCACHE;
                        default:     state_next = ST_IDLE;
                    endcase
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            have_iaddr <= 1'b0;
        end else begin
            state <= state_next;
            if (icache_rsp.resp)
                have_iaddr <= 1'b1;
        end
    end

    // The next-line address is frozen for the whole prefetch.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && state_next == ST_PREFETCH)
            pf_addr_q <= pf_next_addr;
    end

endmodule

// ==== common/mem_sys_macros.svh ====
`ifndef MEM_SYS_MACROS_SVH
`define MEM_SYS_MACROS_SVH

// Width of one cacheline on the memory bus, in bits.
`define MEM_LINE_BITS 256

// Byte address width used by both cache ports and the bus.
`define MEM_ADDR_BITS 32

// Byte offset bits inside a 32-byte line.
`define MEM_OFFSET_BITS 5

`endif

// ==== common/mem_sys_pkg.sv ====
`include "mem_sys_macros.svh"

package mem_sys_pkg;

    typedef logic [`MEM_ADDR_BITS-1:0] word_t;
    typedef logic [`MEM_LINE_BITS-1:0] line_t;

    // Request from one cache port. Held stable until resp.
    typedef struct packed {
        word_t addr;
        logic  read;
        logic  write;
        line_t wdata;
    } cache_req_t;

    typedef struct packed {
        logic  resp;   // One-cycle completion pulse.
        line_t rdata;
    } cache_rsp_t;

    // Wishbone classic, master to slave.
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        line_t dat;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        line_t dat;
    } wb_s2m_t;

    typedef struct packed {
        logic  valid;  // Held until done.
        logic  we;
        word_t adr;
        line_t dat;
    } bus_req_t;

    typedef struct packed {
        logic  done;
        line_t dat;
    } bus_rsp_t;

    // Commands from the arbiter to the prefetch buffer.
    typedef struct packed {
        word_t lookup_addr;
        logic  fill;
        word_t fill_addr;
        line_t fill_data;
        logic  inval;
        word_t inval_addr;
    } pf_ctl_t;

endpackage

// ==== flist.f ====
+incdir+common
common/mem_sys_pkg.sv
arbiter/cache_arbiter.sv
prefetch/prefetch_buffer.sv
verilog/wb_line_master.sv
verilog/mem_subsystem_top.sv
verif/mem_subsystem_asserts.sv
verif/mem_subsystem_tb.sv

// ==== prefetch/prefetch_buffer.sv ====
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module prefetch_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  mem_sys_pkg::pf_ctl_t ctl,
    input  logic                 record,
    input  mem_sys_pkg::word_t   record_addr,
    output logic                 hit,
    output mem_sys_pkg::line_t   data,
    output mem_sys_pkg::word_t   next_addr
);

    localparam int TAG_BITS = `MEM_ADDR_BITS - `MEM_OFFSET_BITS;

    logic                valid;
    logic [TAG_BITS-1:0] tag;
    mem_sys_pkg::line_t  line;
    logic [TAG_BITS-1:0] last_tag;   // Line number of the last instruction access.
    logic [TAG_BITS-1:0] lookup_tag;
    logic [TAG_BITS-1:0] fill_tag;
    logic [TAG_BITS-1:0] inval_tag;

    assign lookup_tag = ctl.lookup_addr[`MEM_ADDR_BITS-1:`MEM_OFFSET_BITS];
    assign fill_tag   = ctl.fill_addr[`MEM_ADDR_BITS-1:`MEM_OFFSET_BITS];
    assign inval_tag  = ctl.inval_addr[`MEM_ADDR_BITS-1:`MEM_OFFSET_BITS];

    // Lookup is purely combinational so the arbiter can answer in the same cycle.
    assign hit  = valid && (tag == lookup_tag);
    assign data = line;

    // The line after the last one, with the offset cleared.
    assign next_addr = {last_tag + 1'b1, {`MEM_OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid    <= 1'b0;
            last_tag <= '0;
        end else begin
            if (ctl.inval && valid && (tag == inval_tag))
                valid <= 1'b0;  // Other lines are left alone.
            if (ctl.fill)
                valid <= 1'b1;
            if (record)
                last_tag <= record_addr[`MEM_ADDR_BITS-1:`MEM_OFFSET_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (ctl.fill) begin
            tag  <= fill_tag;
            line <= ctl.fill_data;
        end
    end

endmodule

// ==== verif/mem_subsystem_asserts.sv ====
`timescale 1ns/1ns

module mem_subsystem_asserts (
    input logic                    clk,
    input logic                    reset,
    input mem_sys_pkg::cache_rsp_t icache_rsp,
    input mem_sys_pkg::cache_rsp_t dcache_rsp,
    input mem_sys_pkg::wb_s2m_t    wb_in,
    input mem_sys_pkg::wb_m2s_t    wb_out
);

    int fail_count = 0;  // Number of assertion failures so far.

    // Everything stays quiet while reset is held.
    reset_quiet: assert property (@(posedge clk)
        reset |-> (!wb_out.cyc && !wb_out.stb && !wb_out.we
                   && !icache_rsp.resp && !dcache_rsp.resp))
        else begin
            fail_count++;
            $error("Bus or responses active during reset");
        end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
        wb_out.stb |-> wb_out.cyc)
        else begin
            fail_count++;
            $error("stb is high without cyc");
        end

    // The master holds its request until the slave acks.
    hold_until_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_out.cyc && wb_out.stb && !wb_in.ack)
        |=> ($stable(wb_out.adr) && $stable(wb_out.we) && $stable(wb_out.dat)))
        else begin
            fail_count++;
            $error("adr, we or dat changed before ack");
        end

    cyc_drops_after_ack: assert property (@(posedge clk) disable iff (reset)
        (wb_out.cyc && wb_in.ack) |=> !wb_out.cyc)
        else begin
            fail_count++;
            $error("cyc still high after ack");
        end

    icache_resp_pulse: assert property (@(posedge clk) disable iff (reset)
        icache_rsp.resp |=> !icache_rsp.resp)
        else begin
            fail_count++;
            $error("icache resp longer than one cycle");
        end

    dcache_resp_pulse: assert property (@(posedge clk) disable iff (reset)
        dcache_rsp.resp |=> !dcache_rsp.resp)
        else begin
            fail_count++;
            $error("dcache resp longer than one cycle");
        end

endmodule

// ==== verif/mem_subsystem_tb.sv ====
`timescale 1ns/1ns
`include "mem_sys_macros.svh"

module mem_subsystem_tb;

    localparam int NUM_REQS = 8;
    localparam int CLK_PERIOD = 100;

    logic                    clk;
    logic                    reset;
    mem_sys_pkg::cache_req_t icache_req;
    mem_sys_pkg::cache_req_t dcache_req;
    mem_sys_pkg::wb_s2m_t    wb_in;
    mem_sys_pkg::cache_rsp_t icache_rsp;
    mem_sys_pkg::cache_rsp_t dcache_rsp;
    mem_sys_pkg::wb_m2s_t    wb_out;

    logic [31:0]         rng;
    int                  errors;
    int                  checks;
    int                  cyc_count;
    logic                cyc_prev;
    mem_sys_pkg::word_t  last_done_adr;
    logic                slave_busy;
    int                  wait_cnt;
    mem_sys_pkg::line_t  shadow [mem_sys_pkg::word_t];  // Lines written by the DUT.

    mem_subsystem_top mem_subsystem_top_i (
        .clk        (clk),
        .reset      (reset),
        .icache_req (icache_req),
        .dcache_req (dcache_req),
        .wb_in      (wb_in),
        .icache_rsp (icache_rsp),
        .dcache_rsp (dcache_rsp),
        .wb_out     (wb_out)
    );

    bind mem_subsystem_top mem_subsystem_asserts mem_subsystem_asserts_i (
        .clk        (clk),
        .reset      (reset),
        .icache_rsp (icache_rsp),
        .dcache_rsp (dcache_rsp),
        .wb_in      (wb_in),
        .wb_out     (wb_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Untouched memory holds each word's byte address XOR 32'h5a5a0000.
    function automatic mem_sys_pkg::line_t pattern_line(input mem_sys_pkg::word_t base);
        mem_sys_pkg::line_t l;
        for (int i = 0; i < `MEM_LINE_BITS / 32; i++)
            l[i*32 +: 32] = (base + 32'(i * 4)) ^ 32'h5a5a0000;
        return l;
    endfunction

    // Wishbone slave with a random ack delay of 1 to 4 cycles.
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_in      <= '0;
            slave_busy <= 1'b0;
            wait_cnt   <= 0;
        end else begin
            wb_in.ack <= 1'b0;
            if (wb_out.cyc && wb_out.stb && !wb_in.ack) begin
                if (!slave_busy) begin
                    rng = xorshift(rng);
                    wait_cnt   <= int'(rng % 4);
                    slave_busy <= 1'b1;
                end else if (wait_cnt == 0) begin
                    slave_busy <= 1'b0;
                    wb_in.ack  <= 1'b1;
                    if (wb_out.we)
                        shadow[wb_out.adr] = wb_out.dat;
                    else if (shadow.exists(wb_out.adr))
                        wb_in.dat <= shadow[wb_out.adr];
                    else
                        wb_in.dat <= pattern_line(wb_out.adr);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

    // Bus monitor for cycle counts and the last completed address.
    always @(posedge clk) begin
        if (!reset) begin
            if (wb_out.cyc && !cyc_prev)
                cyc_count = cyc_count + 1;
            if (wb_out.cyc && wb_in.ack)
                last_done_adr = wb_out.adr;
        end
        cyc_prev = wb_out.cyc;
    end

    task automatic compare_line(input string name, input mem_sys_pkg::line_t exp,
                                input mem_sys_pkg::line_t act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("ERROR %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_int(input string name, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("ERROR %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    // Called just after a rising edge. Holds the request until resp, then drops it.
    task automatic issue_request(input bit is_data, input mem_sys_pkg::word_t addr,
                                 input bit wr, input mem_sys_pkg::line_t wdata,
                                 output mem_sys_pkg::line_t rdata, output int cycles,
                                 output int bus_cycles, output time t_done);
        int start_cyc;
        bit got;
        start_cyc = cyc_count;
        cycles    = 0;
        got       = 0;
        if (is_data) begin
            dcache_req <= '{addr: addr, read: !wr, write: wr, wdata: wdata};
        end else begin
            icache_req <= '{addr: addr, read: 1'b1, write: 1'b0, wdata: '0};
        end
        while (!got) begin
            @(negedge clk);
            cycles++;
            if (is_data && dcache_rsp.resp) begin
                rdata = dcache_rsp.rdata;
                got   = 1;
            end else if (!is_data && icache_rsp.resp) begin
                rdata = icache_rsp.rdata;
                got   = 1;
            end
        end
        t_done     = $time;
        bus_cycles = cyc_count - start_cyc;
        @(posedge clk);
        if (is_data)
            dcache_req <= '0;
        else
            icache_req <= '0;
    endtask

    // Waits until a bus cycle for addr has finished and the buffer has taken it.
    task automatic wait_for_fill(input mem_sys_pkg::word_t addr);
        while (!(last_done_adr == addr && !wb_out.cyc))
            @(negedge clk);
        repeat (2) @(posedge clk);
    endtask

    function automatic mem_sys_pkg::line_t random_line();
        mem_sys_pkg::line_t l;
        for (int i = 0; i < `MEM_LINE_BITS / 32; i++) begin
            rng = xorshift(rng);
            l[i*32 +: 32] = rng;
        end
        return l;
    endfunction

    initial begin
        #((NUM_REQS * 20 + 200) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in time.");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        mem_sys_pkg::line_t rd;
        mem_sys_pkg::line_t rd_d;
        mem_sys_pkg::line_t wline;
        mem_sys_pkg::line_t wline2;
        int                 cyc_n;
        int                 bus_n;
        int                 cyc_d;
        int                 bus_d;
        int                 assert_fails;
        time                t_i;
        time                t_d;
        clk           = 1'b0;
        reset         = 1'b1;
        icache_req    = '0;
        dcache_req    = '0;
        wb_in         = '0;
        rng           = 32'h1d58;
        errors        = 0;
        checks        = 0;
        cyc_count     = 0;
        cyc_prev      = 1'b0;
        last_done_adr = '1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        // Cold icache read, then the next line is prefetched.
        issue_request(0, 32'h1000, 0, '0, rd, cyc_n, bus_n, t_i);
        compare_line("icache_cold_data", pattern_line(32'h1000), rd);
        compare_int("icache_cold_bus_cycles", 1, bus_n);
        wait_for_fill(32'h1020);
        issue_request(0, 32'h1024, 0, '0, rd, cyc_n, bus_n, t_i);
        compare_line("prefetch_hit_data", pattern_line(32'h1020), rd);
        compare_int("prefetch_hit_latency", 2, cyc_n);
        compare_int("prefetch_hit_bus_cycles", 0, bus_n);

        // A write to the buffered line sends the next icache read to the bus.
        wait_for_fill(32'h1040);
        wline = random_line();
        issue_request(1, 32'h1040, 1, wline, rd, cyc_n, bus_n, t_d);
        issue_request(0, 32'h1040, 0, '0, rd, cyc_n, bus_n, t_i);
        compare_line("inval_icache_data", wline, rd);
        compare_int("inval_icache_bus_cycles", 1, bus_n);

        // Data write and read back of one line.
        wline2 = random_line();
        issue_request(1, 32'h2000, 1, wline2, rd, cyc_n, bus_n, t_d);
        issue_request(1, 32'h2008, 0, '0, rd, cyc_n, bus_n, t_d);
        compare_line("dcache_readback", wline2, rd);

        // Both ports in the same cycle.
        fork
            issue_request(0, 32'h3000, 0, '0, rd, cyc_n, bus_n, t_i);
            issue_request(1, 32'h4000, 0, '0, rd_d, cyc_d, bus_d, t_d);
        join
        compare_line("both_icache_data", pattern_line(32'h3000), rd);
        compare_line("both_dcache_data", pattern_line(32'h4000), rd_d);
        compare_int("both_icache_first", 1, int'(t_i < t_d));

        repeat (5) @(posedge clk);
        assert_fails = mem_subsystem_top_i.mem_subsystem_asserts_i.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/mem_subsystem_top.sv ====
`timescale 1ns/1ns

module mem_subsystem_top (
    input  logic                    clk,
    input  logic                    reset,
    input  mem_sys_pkg::cache_req_t icache_req,
    input  mem_sys_pkg::cache_req_t dcache_req,
    input  mem_sys_pkg::wb_s2m_t    wb_in,
    output mem_sys_pkg::cache_rsp_t icache_rsp,
    output mem_sys_pkg::cache_rsp_t dcache_rsp,
    output mem_sys_pkg::wb_m2s_t    wb_out
);

    mem_sys_pkg::pf_ctl_t  pf_ctl;
    logic                  pf_hit;
    mem_sys_pkg::line_t    pf_data;
    mem_sys_pkg::word_t    pf_next_addr;
    mem_sys_pkg::bus_req_t bus_req;
    mem_sys_pkg::bus_rsp_t bus_rsp;

    cache_arbiter cache_arbiter_i (
        .clk          (clk),
        .reset        (reset),
        .icache_req   (icache_req),
        .dcache_req   (dcache_req),
        .pf_hit       (pf_hit),
        .pf_data      (pf_data),
        .pf_next_addr (pf_next_addr),
        .bus_rsp      (bus_rsp),
        .icache_rsp   (icache_rsp),
        .dcache_rsp   (dcache_rsp),
        .pf_ctl       (pf_ctl),
        .bus_req      (bus_req)
    );

    // Every completed instruction read moves the next-line pointer.
    prefetch_buffer prefetch_buffer_i (
        .clk         (clk),
        .reset       (reset),
        .ctl         (pf_ctl),
        .record      (icache_rsp.resp),
        .record_addr (icache_req.addr),
        .hit         (pf_hit),
        .data        (pf_data),
        .next_addr   (pf_next_addr)
    );

    wb_line_master wb_line_master_i (
        .clk    (clk),
        .reset  (reset),
        .req    (bus_req),
        .wb_in  (wb_in),
        .rsp    (bus_rsp),
        .wb_out (wb_out)
    );

endmodule

// ==== verilog/wb_line_master.sv ====
`timescale 1ns/1ns

module wb_line_master (
    input  logic                  clk,
    input  logic                  reset,
    input  mem_sys_pkg::bus_req_t req,
    input  mem_sys_pkg::wb_s2m_t  wb_in,
    output mem_sys_pkg::bus_rsp_t rsp,
    output mem_sys_pkg::wb_m2s_t  wb_out
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t             state;
    logic               start;
    logic               we_q;
    logic               done_q;
    mem_sys_pkg::word_t adr_q;
    mem_sys_pkg::line_t wdat_q;
    mem_sys_pkg::line_t rdat_q;

    // The request is still held while done is out, so it must not start again.
    assign start = (state == ST_IDLE) && req.valid && !done_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= ST_IDLE;
            we_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                state <= ST_BUSY;
                we_q  <= req.we;
            end else if (state == ST_BUSY && wb_in.ack) begin
                state  <= ST_IDLE;  // cyc and stb fall in the cycle after ack.
                we_q   <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q  <= req.adr;
            wdat_q <= req.dat;
        end
        if (state == ST_BUSY && wb_in.ack)
            rdat_q <= wb_in.dat;  // Read data is taken on the ack edge.
    end

    always_comb begin
        wb_out.cyc = (state == ST_BUSY);
        wb_out.stb = (state == ST_BUSY);
        wb_out.we  = we_q;
        wb_out.adr = adr_q;
        wb_out.dat = wdat_q;
    end

    assign rsp.done = done_q;
    assign rsp.dat  = rdat_q;

endmodule
